// ==== design/s4_hazard_unit.sv ====
`timescale 1ns/1ps

// stall / flush control for the fe and em latches
// all outputs are combinational off the latch contents
module s4_hazard_unit (
    input  logic               CLK,
    input  logic               nRST,
    input  s4_pipe_pkg::insn_t ex_insn,     // fe latch, record in execute
    input  s4_pipe_pkg::insn_t mem_insn,    // em latch, record in memory
    input  logic               mispredict,  // branch in execute went the wrong way
    input  logic               i_mem_busy,  // fetch word not ready
    input  logic               d_mem_busy,  // data access of mem_insn not done
    input  logic               trap_flush,  // trap taken this cycle
    output logic               pc_en,
    output logic               redirect,
    output logic               fe_stall,
    output logic               fe_flush,
    output logic               em_stall,
    output logic               em_flush,
    output logic               dmem_wait
);

    logic mem_is_load;   // valid load in memory
    logic mem_access;    // valid load or store in memory
    logic rs1_match;
    logic rs2_match;
    logic load_use;
    logic branch_jump;
    logic ex_vsetvl;     // valid vsetvl sitting in execute
    logic vsetvl_hold;
    logic vsetvl_flag;   // vsetvl has already waited its bubble

    assign mem_is_load = mem_insn.valid && (mem_insn.op == s4_pipe_pkg::OP_LOAD);
    assign mem_access  = mem_insn.valid &&
                         ((mem_insn.op == s4_pipe_pkg::OP_LOAD) ||
                          (mem_insn.op == s4_pipe_pkg::OP_STORE));

    // load result only exists after memory, no forwarding path
    assign rs1_match = (ex_insn.rs1 == mem_insn.rd) && (mem_insn.rd != '0);
    assign rs2_match = (ex_insn.rs2 == mem_insn.rd) && (mem_insn.rd != '0);
    assign load_use  = mem_is_load && ex_insn.valid && (rs1_match || rs2_match);

    // jumps always redirect, branches only when predicted wrong
    assign branch_jump = ex_insn.valid &&
                         ((ex_insn.op == s4_pipe_pkg::OP_JUMP) ||
                          ((ex_insn.op == s4_pipe_pkg::OP_BRANCH) && mispredict));

    assign dmem_wait = mem_access && d_mem_busy;

    // a vsetvl first holds in execute one cycle so memory drains
    // then the flag keeps fetch shut while it moves into memory
    assign ex_vsetvl   = ex_insn.valid && (ex_insn.op == s4_pipe_pkg::OP_VSETVL);
    assign vsetvl_hold = ex_vsetvl && !vsetvl_flag;

    always_comb begin
        pc_en    = 1'b1;
        redirect = 1'b0;
        fe_stall = 1'b0;
        fe_flush = 1'b0;
        em_stall = 1'b0;
        em_flush = 1'b0;
        if (dmem_wait) begin
            // slow data memory freezes the whole pipe
            fe_stall = 1'b1;
            em_stall = 1'b1;
            pc_en    = 1'b0;
        end else if (trap_flush || branch_jump) begin
            fe_flush = 1'b1;   // drop wrong-path fetch
            em_flush = 1'b1;   // execute record does not go on
            redirect = 1'b1;
            pc_en    = 1'b1;   // pc loads the new target
        end else if (load_use || vsetvl_hold) begin
            fe_stall = 1'b1;   // keep consumer in execute
            em_flush = 1'b1;   // bubble into memory
            pc_en    = 1'b0;
        end else if (i_mem_busy || vsetvl_flag) begin
            fe_flush = 1'b1;   // bubble into execute, em keeps moving
            pc_en    = 1'b0;
        end
    end

    // flag goes up on the edge where the vsetvl is held in execute
    // and drops once fe flushes, which is when the vsetvl moves on
    // or when a redirect kills it
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vsetvl_flag <= 1'b0;
        end else if (fe_flush) begin
            vsetvl_flag <= 1'b0;
        end else if (ex_vsetvl && fe_stall) begin
            vsetvl_flag <= 1'b1;
        end
    end

endmodule

// ==== design/s4_pipe_ctrl.sv ====
`timescale 1ns/1ps

// control core of the four stage pipe
// fetch -> fe latch -> execute -> em latch -> memory -> writeback
module s4_pipe_ctrl (
    input  logic                CLK,
    input  logic                nRST,
    input  s4_pipe_pkg::insn_t  fetch_insn,  // record offered by fetch
    input  logic                i_mem_busy,
    input  logic                d_mem_busy,
    input  logic                mispredict,
    input  logic                intr,
    input  s4_pipe_pkg::fault_t faults,
    output logic                pc_en,
    output logic                redirect,
    output s4_pipe_pkg::insn_t  ex_insn,
    output s4_pipe_pkg::insn_t  mem_insn,
    output s4_pipe_pkg::trap_t  trap
);

    logic fe_stall;
    logic fe_flush;
    logic em_stall;
    logic em_flush;
    logic dmem_wait;   // hazard unit -> trap ctrl
    logic trap_flush;  // trap ctrl -> hazard unit

    s4_hazard_unit s4_hazard_unit_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .ex_insn    (ex_insn),
        .mem_insn   (mem_insn),
        .mispredict (mispredict),
        .i_mem_busy (i_mem_busy),
        .d_mem_busy (d_mem_busy),
        .trap_flush (trap_flush),
        .pc_en      (pc_en),
        .redirect   (redirect),
        .fe_stall   (fe_stall),
        .fe_flush   (fe_flush),
        .em_stall   (em_stall),
        .em_flush   (em_flush),
        .dmem_wait  (dmem_wait)
    );

    // fetch -> execute
    s4_stage_latch fe_latch (
        .CLK   (CLK),
        .nRST  (nRST),
        .stall (fe_stall),
        .flush (fe_flush),
        .d     (fetch_insn),
        .q     (ex_insn)
    );

    // execute -> memory
    s4_stage_latch em_latch (
        .CLK   (CLK),
        .nRST  (nRST),
        .stall (em_stall),
        .flush (em_flush),
        .d     (ex_insn),
        .q     (mem_insn)
    );

    s4_trap_ctrl s4_trap_ctrl_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .faults     (faults),
        .intr       (intr),
        .dmem_wait  (dmem_wait),
        .fetch_pc   (fetch_insn.pc),  // epc for fetch faults
        .ex_insn    (ex_insn),
        .mem_insn   (mem_insn),
        .trap_flush (trap_flush),
        .trap       (trap)
    );

endmodule

// ==== design/s4_pipe_ctrl_cfg.svh ====
`ifndef S4_PIPE_CTRL_CFG_SVH
`define S4_PIPE_CTRL_CFG_SVH

// datapath widths seen by the pipeline control core

`define S4_WORD_W  32 // pc and data word
`define S4_REG_W   5  // register index x0..x31

// trap cause encoding width
`define S4_CAUSE_W 3

`endif

// ==== design/s4_pipe_pkg.sv ====
`include "s4_pipe_ctrl_cfg.svh"

package s4_pipe_pkg;

    // instruction class as far as hazard detection cares
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_BRANCH = 3'd3,
        OP_JUMP   = 3'd4,
        OP_VSETVL = 3'd5  // serialising, nothing younger may pass it
    } op_e;

    // trap causes reported to the privilege block
    typedef enum logic [`S4_CAUSE_W-1:0] {
        CAUSE_NONE        = 3'd0,
        CAUSE_FETCH_FAULT = 3'd1,
        CAUSE_ILLEGAL     = 3'd2,
        CAUSE_LOAD_FAULT  = 3'd3,
        CAUSE_STORE_FAULT = 3'd4,
        CAUSE_INTERRUPT   = 3'd5
    } cause_e;

    // one in-flight instruction, valid low means bubble
    typedef struct packed {
        logic                 valid;
        logic [`S4_WORD_W-1:0] pc;
        op_e                  op;
        logic [`S4_REG_W-1:0]  rd;   // destination, x0 never written
        logic [`S4_REG_W-1:0]  rs1;
        logic [`S4_REG_W-1:0]  rs2;
    } insn_t;

    // fault strobes, one per reporting stage
    typedef struct packed {
        logic fetch_fault;  // instruction access fault
        logic illegal;      // decode saw an illegal encoding
        logic load_fault;
        logic store_fault;
    } fault_t;

    // registered trap record
    typedef struct packed {
        logic                  valid; // single cycle pulse
        cause_e                cause;
        logic [`S4_WORD_W-1:0] epc;
    } trap_t;

endpackage

// ==== design/s4_stage_latch.sv ====
`timescale 1ns/1ps

// one pipeline register between two stages
// stall keeps the record, flush turns it into a bubble
module s4_stage_latch (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               stall,  // hold current record
    input  logic               flush,  // load a bubble
    input  s4_pipe_pkg::insn_t d,      // record from the upstream stage
    output s4_pipe_pkg::insn_t q       // record seen by the downstream stage
);

    // priority is stall > flush > load
    // a stalled stage must not lose its record even if a flush
    // arrives in the same cycle, the flush is reissued once the
    // stall drops
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            q <= '0;            // pipe starts empty
        end else if (stall) begin
            q <= q;             // downstream busy
        end else if (flush) begin
            q <= '0;            // bubble, valid low
        end else begin
            q <= d;             // normal advance
        end
    end

    // the whole record is cleared on a flush rather than only valid
    // so a bubble looks the same in every latch and never carries
    // a stale rd into the load-use compare

endmodule

// ==== design/s4_trap_ctrl.sv ====
`timescale 1ns/1ps

`include "s4_pipe_ctrl_cfg.svh"

// exception / interrupt arbitration and the trap record
module s4_trap_ctrl (
    input  logic                  CLK,
    input  logic                  nRST,
    input  s4_pipe_pkg::fault_t   faults,
    input  logic                  intr,       // interrupt pending, level
    input  logic                  dmem_wait,  // data access still outstanding
    input  logic [`S4_WORD_W-1:0] fetch_pc,
    input  s4_pipe_pkg::insn_t    ex_insn,
    input  s4_pipe_pkg::insn_t    mem_insn,
    output logic                  trap_flush,
    output s4_pipe_pkg::trap_t    trap
);

    logic                  mem_load_fault;
    logic                  mem_store_fault;
    logic                  ex_illegal;
    s4_pipe_pkg::cause_e   cause_sel;
    logic [`S4_WORD_W-1:0] epc_sel;
    logic                  trap_valid_q;
    s4_pipe_pkg::cause_e   cause_q;
    logic [`S4_WORD_W-1:0] epc_q;

    // a fault only counts against a record of the matching kind
    assign mem_load_fault  = mem_insn.valid && faults.load_fault &&
                             (mem_insn.op == s4_pipe_pkg::OP_LOAD);
    assign mem_store_fault = mem_insn.valid && faults.store_fault &&
                             (mem_insn.op == s4_pipe_pkg::OP_STORE);
    assign ex_illegal      = ex_insn.valid && faults.illegal;

    // oldest stage first, interrupt last
    always_comb begin
        cause_sel = s4_pipe_pkg::CAUSE_NONE;
        epc_sel   = fetch_pc;
        if (mem_load_fault) begin
            cause_sel = s4_pipe_pkg::CAUSE_LOAD_FAULT;
            epc_sel   = mem_insn.pc;
        end else if (mem_store_fault) begin
            cause_sel = s4_pipe_pkg::CAUSE_STORE_FAULT;
            epc_sel   = mem_insn.pc;
        end else if (ex_illegal) begin
            cause_sel = s4_pipe_pkg::CAUSE_ILLEGAL;
            epc_sel   = ex_insn.pc;
        end else if (faults.fetch_fault) begin
            cause_sel = s4_pipe_pkg::CAUSE_FETCH_FAULT;
        end else if (intr) begin
            cause_sel = s4_pipe_pkg::CAUSE_INTERRUPT;
            // resume at the oldest record still in flight
            if (mem_insn.valid) begin
                epc_sel = mem_insn.pc;
            end else if (ex_insn.valid) begin
                epc_sel = ex_insn.pc;
            end
        end
    end

    // nothing is taken while memory holds the pipe, and only one
    // trap per redirect since fetch is refilling right after it
    assign trap_flush = (cause_sel != s4_pipe_pkg::CAUSE_NONE) &&
                        !dmem_wait && !trap_valid_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            trap_valid_q <= 1'b0;
        end else begin
            trap_valid_q <= trap_flush;  // one cycle pulse
        end
    end

    // cause and epc stay put until the next trap
    always_ff @(posedge CLK) begin
        if (trap_flush) begin
            cause_q <= cause_sel;
            epc_q   <= epc_sel;
        end
    end

    assign trap = '{valid: trap_valid_q, cause: cause_q, epc: epc_q};

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the s4_pipe_ctrl testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f s4_pipe_ctrl.f \
    --top-module s4_pipe_ctrl_tb \
    -o s4_pipe_ctrl_sim

# the simulator may exit nonzero on failure, the log decides below
./obj_dir/s4_pipe_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    exit 1
fi
grep -q "\*\* PASS \*\*" sim.log

// ==== s4_pipe_ctrl.f ====
+incdir+design
design/s4_pipe_pkg.sv
design/s4_stage_latch.sv
design/s4_hazard_unit.sv
design/s4_trap_ctrl.sv
design/s4_pipe_ctrl.sv
verification/s4_pipe_ctrl_checker.sv
verification/s4_pipe_ctrl_tb.sv

// ==== verification/s4_pipe_ctrl_checker.sv ====
`timescale 1ns/1ps

// protocol assertions on the latch controls and the trap pulse
module s4_pipe_ctrl_checker (
    input logic CLK,
    input logic nRST,
    input logic fe_stall,
    input logic fe_flush,
    input logic em_stall,
    input logic em_flush,
    input logic trap_valid
);

    // a latch gets either hold or bubble, never both
    fe_excl: assert property (@(posedge CLK) disable iff (!nRST) !(fe_stall && fe_flush))
        else $error("fe latch sees stall and flush together");

    em_excl: assert property (@(posedge CLK) disable iff (!nRST) !(em_stall && em_flush))
        else $error("em latch sees stall and flush together");

    // trap record valid is a single cycle pulse
    trap_pulse: assert property (@(posedge CLK) disable iff (!nRST)
                                 trap_valid |=> !trap_valid)
        else $error("trap valid held for two cycles");

endmodule

bind s4_hazard_unit s4_pipe_ctrl_checker hazard_chk (
    .CLK        (CLK),
    .nRST       (nRST),
    .fe_stall   (fe_stall),
    .fe_flush   (fe_flush),
    .em_stall   (em_stall),
    .em_flush   (em_flush),
    .trap_valid (1'b0)      // no trap here
);

bind s4_trap_ctrl s4_pipe_ctrl_checker trap_chk (
    .CLK        (CLK),
    .nRST       (nRST),
    .fe_stall   (1'b0),
    .fe_flush   (1'b0),
    .em_stall   (1'b0),
    .em_flush   (1'b0),
    .trap_valid (trap.valid)
);

// ==== verification/s4_pipe_ctrl_tb.sv ====
`timescale 1ns/1ps

`include "s4_pipe_ctrl_cfg.svh"

module s4_pipe_ctrl_tb;

    logic                CLK;
    logic                nRST;
    s4_pipe_pkg::insn_t  fetch_insn;
    logic                i_mem_busy;
    logic                d_mem_busy;
    logic                mispredict;
    logic                intr;
    s4_pipe_pkg::fault_t faults;
    logic                pc_en;
    logic                redirect;
    s4_pipe_pkg::insn_t  ex_insn;
    s4_pipe_pkg::insn_t  mem_insn;
    s4_pipe_pkg::trap_t  trap;
    logic [15:0]         lfsr_q = 16'd38056;  // fixed seed

    s4_pipe_ctrl s4_pipe_ctrl_i (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;  // 40 ns period
    end

    // fibonacci lfsr x^16+x^14+x^13+x^11+1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // random register index from five lfsr bits
    function automatic logic [4:0] pick_reg();
        logic [31:0] v;
        v = rand_bits(5);
        return v[4:0];
    endfunction

    function automatic s4_pipe_pkg::insn_t make_insn(input s4_pipe_pkg::op_e op,
                                                     input logic [4:0] rd,
                                                     input logic [4:0] rs1,
                                                     input logic [4:0] rs2);
        s4_pipe_pkg::insn_t r;
        logic [31:0]        bits;
        bits    = rand_bits(`S4_WORD_W - 2);
        r.valid = 1'b1;
        r.pc    = {bits[`S4_WORD_W-3:0], 2'b00};  // word aligned
        r.op    = op;
        r.rd    = rd;
        r.rs1   = rs1;
        r.rs2   = rs2;
        return r;
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (expected !== actual) begin
            abort($sformatf("MISMATCH %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // offer one record on the rising edge
    task automatic offer(input s4_pipe_pkg::insn_t r);
        @(posedge CLK);
        fetch_insn <= r;
    endtask

    // drain the pipe with bubbles and quiet strobes
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge CLK);
            fetch_insn <= '0;
            i_mem_busy <= 1'b0;
            d_mem_busy <= 1'b0;
            mispredict <= 1'b0;
            intr       <= 1'b0;
            faults     <= '0;
        end
    endtask

    task automatic wait_mem_op(input string name, input s4_pipe_pkg::op_e op);
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!(mem_insn.valid && mem_insn.op == op) && n < 20);
        if (!(mem_insn.valid && mem_insn.op == op)) begin
            abort($sformatf("%s: record never reached memory", name));
        end
    endtask

    task automatic expect_trap(input string name, input s4_pipe_pkg::cause_e cause,
                               input logic [31:0] epc);
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!trap.valid && n < 20);
        if (!trap.valid) abort($sformatf("%s: no trap pulse seen", name));
        check_val({name, " cause"}, 64'(cause), 64'(trap.cause));
        check_val({name, " epc"}, 64'(epc), 64'(trap.epc));
        @(posedge CLK);
        intr   <= 1'b0;
        faults <= '0;
        @(negedge CLK);
        check_val({name, " pulse end"}, 0, 64'(trap.valid));
    endtask

    task automatic flow_after_reset();
        s4_pipe_pkg::insn_t r[3];
        @(negedge CLK);
        check_val("reset mem valid", 0, 64'(mem_insn.valid));
        check_val("reset trap valid", 0, 64'(trap.valid));
        check_val("reset redirect", 0, 64'(redirect));
        for (int i = 0; i < 3; i++) r[i] = make_insn(s4_pipe_pkg::OP_ALU, 5'd1, 5'd2, 5'd3);
        offer(r[0]);
        offer(r[1]);
        offer(r[2]);
        @(negedge CLK);
        check_val("flow r0", 64'(r[0]), 64'(mem_insn));  // two edges after offer
        offer('0);
        @(negedge CLK);
        check_val("flow r1", 64'(r[1]), 64'(mem_insn));
        @(negedge CLK);
        check_val("flow r2", 64'(r[2]), 64'(mem_insn));
        idle(3);
    endtask

    task automatic load_use_bubble();
        s4_pipe_pkg::insn_t ld;
        s4_pipe_pkg::insn_t alu;
        logic [4:0]         rd;
        rd = pick_reg();
        if (rd == 0) rd = 5'd7;   // x0 never hazards
        ld  = make_insn(s4_pipe_pkg::OP_LOAD, rd, pick_reg(), pick_reg());
        alu = make_insn(s4_pipe_pkg::OP_ALU, pick_reg(), rd, pick_reg());
        offer(ld);
        offer(alu);
        offer('0);
        @(negedge CLK);
        check_val("load_use load", 64'(ld), 64'(mem_insn));
        check_val("load_use pc_en low", 0, 64'(pc_en));
        @(negedge CLK);
        check_val("load_use bubble", 0, 64'(mem_insn.valid));
        check_val("load_use pc_en back", 1, 64'(pc_en));
        @(negedge CLK);
        check_val("load_use alu", 64'(alu), 64'(mem_insn));
        idle(3);
    endtask

    task automatic redirect_flush(input s4_pipe_pkg::op_e op, input logic mp);
        s4_pipe_pkg::insn_t br;
        s4_pipe_pkg::insn_t nxt;
        br  = make_insn(op, 5'd0, 5'd0, 5'd0);
        nxt = make_insn(s4_pipe_pkg::OP_ALU, 5'd4, 5'd5, 5'd6);
        offer(br);
        offer(nxt);
        mispredict <= mp;
        @(negedge CLK);
        check_val("flush redirect", 1, 64'(redirect));  // branch now in execute
        offer('0);
        mispredict <= 1'b0;
        repeat (4) begin
            @(negedge CLK);
            check_val("flush follower dropped", 0, 64'(mem_insn.valid));
        end
        idle(2);
    endtask

    task automatic memory_waits();
        s4_pipe_pkg::insn_t ld;
        s4_pipe_pkg::insn_t a;
        s4_pipe_pkg::insn_t v;
        int                 cycles;
        int                 n;
        cycles = 1 + (rand_bits(8) % 6);
        ld = make_insn(s4_pipe_pkg::OP_LOAD, 5'd9, 5'd1, 5'd2);
        a  = make_insn(s4_pipe_pkg::OP_ALU, 5'd3, 5'd0, 5'd0);   // no load-use
        offer(ld);
        offer(a);
        d_mem_busy <= 1'b1;
        offer(make_insn(s4_pipe_pkg::OP_ALU, 5'd4, 5'd0, 5'd0));
        for (int i = 0; i < cycles; i++) begin
            @(negedge CLK);
            check_val("dmem mem held", 64'(ld), 64'(mem_insn));
            check_val("dmem ex held", 64'(a), 64'(ex_insn));
            check_val("dmem pc_en", 0, 64'(pc_en));
            @(posedge CLK);
            if (i == cycles - 1) d_mem_busy <= 1'b0;
        end
        wait_mem_op("dmem release", s4_pipe_pkg::OP_ALU);
        check_val("dmem alu", 64'(a), 64'(mem_insn));
        idle(3);
        // vsetvl keeps fetch shut until it sits in memory
        v = make_insn(s4_pipe_pkg::OP_VSETVL, 5'd1, 5'd2, 5'd0);
        offer(v);
        offer('0);
        n = 0;
        @(negedge CLK);
        while (!(mem_insn.valid && mem_insn.op == s4_pipe_pkg::OP_VSETVL)) begin
            check_val("vsetvl pc_en", 0, 64'(pc_en));
            n++;
            if (n > 10) abort("vsetvl never reached memory");
            @(negedge CLK);
        end
        check_val("vsetvl released", 1, 64'(pc_en));
        idle(2);
        // slow fetch turns the offered record into a bubble
        offer(make_insn(s4_pipe_pkg::OP_ALU, 5'd1, 5'd0, 5'd0));
        i_mem_busy <= 1'b1;
        @(negedge CLK);
        check_val("imem pc_en", 0, 64'(pc_en));
        @(posedge CLK);
        i_mem_busy <= 1'b0;
        @(negedge CLK);
        check_val("imem bubble", 0, 64'(ex_insn.valid));
        idle(3);
    endtask

    task automatic trap_reporting();
        s4_pipe_pkg::insn_t st;
        s4_pipe_pkg::insn_t f;
        s4_pipe_pkg::insn_t ld;
        int                 cycles;
        st = make_insn(s4_pipe_pkg::OP_STORE, 5'd0, 5'd1, 5'd2);
        offer(st);
        offer(make_insn(s4_pipe_pkg::OP_ALU, 5'd3, 5'd0, 5'd0));
        offer('0);
        faults <= '{fetch_fault: 1'b0, illegal: 1'b1, load_fault: 1'b0, store_fault: 1'b1};
        expect_trap("store vs illegal", s4_pipe_pkg::CAUSE_STORE_FAULT, st.pc);
        idle(3);
        f = make_insn(s4_pipe_pkg::OP_ALU, 5'd1, 5'd0, 5'd0);
        offer(f);
        faults <= '{fetch_fault: 1'b1, illegal: 1'b0, load_fault: 1'b0, store_fault: 1'b0};
        expect_trap("fetch fault", s4_pipe_pkg::CAUSE_FETCH_FAULT, f.pc);
        idle(3);
        // interrupt must wait out the data access
        cycles = 1 + (rand_bits(8) % 6);
        ld = make_insn(s4_pipe_pkg::OP_LOAD, 5'd5, 5'd0, 5'd0);
        offer(ld);
        offer('0);
        d_mem_busy <= 1'b1;
        @(posedge CLK);
        intr <= 1'b1;
        for (int i = 0; i < cycles; i++) begin
            @(posedge CLK);
            if (i == cycles - 1) d_mem_busy <= 1'b0;
            @(negedge CLK);
            check_val("intr deferred", 0, 64'(trap.valid));  // edge inside the wait
        end
        expect_trap("intr after wait", s4_pipe_pkg::CAUSE_INTERRUPT, ld.pc);
        idle(3);
    endtask

    initial begin
        #200000;
        abort("simulation timed out");
    end

    initial begin
        nRST       <= 1'b0;
        fetch_insn <= '0;
        i_mem_busy <= 1'b0;
        d_mem_busy <= 1'b0;
        mispredict <= 1'b0;
        intr       <= 1'b0;
        faults     <= '0;
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        flow_after_reset();
        load_use_bubble();
        redirect_flush(s4_pipe_pkg::OP_BRANCH, 1'b1);
        redirect_flush(s4_pipe_pkg::OP_JUMP, 1'b0);
        memory_waits();
        trap_reporting();
        $display("** PASS **");
        $finish;
    end

endmodule
